// File: logic/raster_pkg.sv
////////////////////
// Rasterizer package
// Tile and quad geometry, datapath widths and the output word
////////////////////
package raster_pkg;

    // Tile geometry
    localparam int TILE_SIZE      = 4;
    localparam int QUAD_SIZE      = 2;
    localparam int QUADS_PER_ROW  = TILE_SIZE / QUAD_SIZE;
    localparam int QUADS_PER_TILE = QUADS_PER_ROW * QUADS_PER_ROW;
    localparam int QUAD_IDX_BITS  = $clog2(QUADS_PER_TILE);
    localparam int QUAD_SHIFT     = $clog2(QUAD_SIZE);

    // Datapath widths
    localparam int DIM_BITS       = 8;
    localparam int PID_BITS       = 8;
    localparam int COEF_BITS      = 12;
    localparam int PROD_BITS      = COEF_BITS + DIM_BITS + 1;
    localparam int EDGE_BITS      = 24;
    localparam int QUAD_MASK_BITS = 4;
    localparam int STAMP_CNT_BITS = 3;

    // Output word layout
    localparam int OUT_BITS       = 24;
    localparam int POS_BITS       = (OUT_BITS - QUAD_MASK_BITS - PID_BITS) / 2;
    localparam int SUM_PAD_BITS   = OUT_BITS - STAMP_CNT_BITS - PID_BITS;

    // Stamp positions are in quad units and pid sits in the low byte of both views
    typedef union packed {
        struct packed {
            logic [POS_BITS-1:0]       pos_x;
            logic [POS_BITS-1:0]       pos_y;
            logic [QUAD_MASK_BITS-1:0] mask;
            logic [PID_BITS-1:0]       pid;
        } stamp;
        struct packed {
            logic [SUM_PAD_BITS-1:0]   pad;
            logic [STAMP_CNT_BITS-1:0] count;
            logic [PID_BITS-1:0]       pid;
        } summary;
    } raster_out_t;

endpackage

// File: logic/raster_decode.sv
////////////////////
// Raster decode
// Takes a primitive over req/ack and evaluates its edges at the tile origin
////////////////////
`timescale 1ns/1ps

module raster_decode import raster_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_req,
    input  logic [DIM_BITS-1:0]         xloc,
    input  logic [DIM_BITS-1:0]         yloc,
    input  logic [PID_BITS-1:0]         pid,
    input  logic signed [COEF_BITS-1:0] a0,
    input  logic signed [COEF_BITS-1:0] b0,
    input  logic signed [COEF_BITS-1:0] c0,
    input  logic signed [COEF_BITS-1:0] a1,
    input  logic signed [COEF_BITS-1:0] b1,
    input  logic signed [COEF_BITS-1:0] c1,
    input  logic signed [COEF_BITS-1:0] a2,
    input  logic signed [COEF_BITS-1:0] b2,
    input  logic signed [COEF_BITS-1:0] c2,
    input  logic                        prim_take,
    output logic                        in_ack,
    output logic                        prim_valid,
    output logic signed [EDGE_BITS-1:0] e0,
    output logic signed [EDGE_BITS-1:0] e1,
    output logic signed [EDGE_BITS-1:0] e2,
    output logic signed [COEF_BITS-1:0] ea0,
    output logic signed [COEF_BITS-1:0] eb0,
    output logic signed [COEF_BITS-1:0] ea1,
    output logic signed [COEF_BITS-1:0] eb1,
    output logic signed [COEF_BITS-1:0] ea2,
    output logic signed [COEF_BITS-1:0] eb2,
    output logic [DIM_BITS-1:0]         prim_x,
    output logic [DIM_BITS-1:0]         prim_y,
    output logic [PID_BITS-1:0]         prim_pid
);

    logic signed [COEF_BITS-1:0] in_a [3];
    logic signed [COEF_BITS-1:0] in_b [3];
    logic signed [COEF_BITS-1:0] in_c [3];

    logic                        accept;
    logic                        s1_valid;
    logic                        s2_valid;
    logic [DIM_BITS-1:0]         s1_x;
    logic [DIM_BITS-1:0]         s1_y;
    logic [PID_BITS-1:0]         s1_pid;
    logic signed [COEF_BITS-1:0] s1_a [3];
    logic signed [COEF_BITS-1:0] s1_b [3];
    logic signed [COEF_BITS-1:0] s1_c [3];
    logic signed [PROD_BITS-1:0] s2_ax [3];
    logic signed [PROD_BITS-1:0] s2_by [3];
    logic signed [EDGE_BITS-1:0] hold_e [3];

    assign in_a = '{a0, a1, a2};
    assign in_b = '{b0, b1, b2};
    assign in_c = '{c0, c1, c2};

    // Only one primitive in flight between capture and hand-off
    assign accept = in_req && !in_ack && !(s1_valid || s2_valid || prim_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack     <= 1'b0;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            prim_valid <= 1'b0;
        end else begin
            if (accept) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end
            s1_valid <= accept;
            s2_valid <= s1_valid;
            if (s2_valid) begin
                prim_valid <= 1'b1;
            end else if (prim_take) begin
                prim_valid <= 1'b0;
            end
        end
    end

    // Input fields stay put until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_x   <= xloc;
            s1_y   <= yloc;
            s1_pid <= pid;
            for (int k = 0; k < 3; k++) begin
                s1_a[k] <= in_a[k];
                s1_b[k] <= in_b[k];
                s1_c[k] <= in_c[k];
            end
        end
        if (s1_valid) begin
            for (int k = 0; k < 3; k++) begin
                s2_ax[k] <= s1_a[k] * $signed({1'b0, s1_x});
                s2_by[k] <= s1_b[k] * $signed({1'b0, s1_y});
            end
        end
        if (s2_valid) begin
            for (int k = 0; k < 3; k++) begin
                hold_e[k] <= s2_ax[k] + s2_by[k] + s1_c[k];
            end
        end
    end

    assign e0       = hold_e[0];
    assign e1       = hold_e[1];
    assign e2       = hold_e[2];
    assign ea0      = s1_a[0];
    assign eb0      = s1_b[0];
    assign ea1      = s1_a[1];
    assign eb1      = s1_b[1];
    assign ea2      = s1_a[2];
    assign eb2      = s1_b[2];
    assign prim_x   = s1_x;
    assign prim_y   = s1_y;
    assign prim_pid = s1_pid;

    // Ack only answers a request seen on the previous edge
    assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req));

endmodule

// File: logic/raster_execute.sv
////////////////////
// Raster execute
// Walks the quads of a tile and forms per-quad coverage masks
////////////////////
`timescale 1ns/1ps

module raster_execute import raster_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        prim_valid,
    input  logic signed [EDGE_BITS-1:0] e0,
    input  logic signed [EDGE_BITS-1:0] e1,
    input  logic signed [EDGE_BITS-1:0] e2,
    input  logic signed [COEF_BITS-1:0] ea0,
    input  logic signed [COEF_BITS-1:0] eb0,
    input  logic signed [COEF_BITS-1:0] ea1,
    input  logic signed [COEF_BITS-1:0] eb1,
    input  logic signed [COEF_BITS-1:0] ea2,
    input  logic signed [COEF_BITS-1:0] eb2,
    input  logic [DIM_BITS-1:0]         prim_x,
    input  logic [DIM_BITS-1:0]         prim_y,
    input  logic [PID_BITS-1:0]         prim_pid,
    input  logic                        quad_ready,
    output logic                        prim_take,
    output logic                        quad_valid,
    output logic [DIM_BITS-1:0]         quad_x,
    output logic [DIM_BITS-1:0]         quad_y,
    output logic [QUAD_MASK_BITS-1:0]   quad_mask,
    output logic [PID_BITS-1:0]         quad_pid,
    output logic                        quad_last
);

    logic signed [EDGE_BITS-1:0] in_e [3];
    logic signed [COEF_BITS-1:0] in_a [3];
    logic signed [COEF_BITS-1:0] in_b [3];

    logic [QUAD_IDX_BITS-1:0]    idx;
    logic [DIM_BITS-1:0]         base_x;
    logic [DIM_BITS-1:0]         base_y;
    logic [PID_BITS-1:0]         cur_pid;
    logic signed [EDGE_BITS-1:0] cur_e [3];
    logic signed [EDGE_BITS-1:0] row_e [3];
    logic signed [COEF_BITS-1:0] step_a [3];
    logic signed [COEF_BITS-1:0] step_b [3];
    logic                        quad_fire;
    logic                        row_end;

    assign in_e = '{e0, e1, e2};
    assign in_a = '{ea0, ea1, ea2};
    assign in_b = '{eb0, eb1, eb2};

    assign quad_last = (idx == QUAD_IDX_BITS'(QUADS_PER_TILE - 1));
    assign quad_fire = quad_valid && quad_ready;
    assign prim_take = prim_valid && (!quad_valid || (quad_fire && quad_last));
    assign row_end   = (int'(idx) % QUADS_PER_ROW) == (QUADS_PER_ROW - 1);

    // Row-major quad offsets from the tile origin
    assign quad_x   = base_x + DIM_BITS'((int'(idx) % QUADS_PER_ROW) * QUAD_SIZE);
    assign quad_y   = base_y + DIM_BITS'((int'(idx) / QUADS_PER_ROW) * QUAD_SIZE);
    assign quad_pid = cur_pid;

    always_ff @(posedge clk) begin
        if (reset) begin
            quad_valid <= 1'b0;
            idx        <= '0;
        end else if (prim_take) begin
            quad_valid <= 1'b1;
            idx        <= '0;
        end else if (quad_fire) begin
            quad_valid <= !quad_last;
            idx        <= idx + 1'b1;
        end
    end

    // Edge values track the top-left pixel of the current quad
    always_ff @(posedge clk) begin
        if (prim_take) begin
            base_x  <= prim_x;
            base_y  <= prim_y;
            cur_pid <= prim_pid;
            for (int k = 0; k < 3; k++) begin
                cur_e[k]  <= in_e[k];
                row_e[k]  <= in_e[k];
                step_a[k] <= in_a[k];
                step_b[k] <= in_b[k];
            end
        end else if (quad_fire) begin
            for (int k = 0; k < 3; k++) begin
                if (row_end) begin
                    row_e[k] <= row_e[k] + EDGE_BITS'(step_b[k] * QUAD_SIZE);
                    cur_e[k] <= row_e[k] + EDGE_BITS'(step_b[k] * QUAD_SIZE);
                end else begin
                    cur_e[k] <= cur_e[k] + EDGE_BITS'(step_a[k] * QUAD_SIZE);
                end
            end
        end
    end

    // Zero on an edge still counts as inside
    always_comb begin
        logic signed [EDGE_BITS-1:0] val;
        for (int p = 0; p < QUAD_MASK_BITS; p++) begin
            quad_mask[p] = 1'b1;
            for (int k = 0; k < 3; k++) begin
                val = cur_e[k] + EDGE_BITS'((p % QUAD_SIZE) * step_a[k])
                               + EDGE_BITS'((p / QUAD_SIZE) * step_b[k]);
                if (val < 0) begin
                    quad_mask[p] = 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        quad_valid && !quad_ready |=>
            quad_valid && $stable({quad_x, quad_y, quad_mask, quad_pid, quad_last}));

endmodule

// File: logic/raster_result.sv
////////////////////
// Raster result
// Packs stamps and per-primitive summaries onto the req/ack output
////////////////////
`timescale 1ns/1ps

module raster_result import raster_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      quad_valid,
    input  logic [DIM_BITS-1:0]       quad_x,
    input  logic [DIM_BITS-1:0]       quad_y,
    input  logic [QUAD_MASK_BITS-1:0] quad_mask,
    input  logic [PID_BITS-1:0]       quad_pid,
    input  logic                      quad_last,
    input  logic                      out_ack,
    output logic                      quad_ready,
    output logic                      out_req,
    output logic                      out_is_summary,
    output raster_out_t               out_word
);

    logic                      ack_wait;
    logic                      sum_pend;
    logic [STAMP_CNT_BITS-1:0] count;
    logic [PID_BITS-1:0]       sum_pid;
    logic                      quad_fire;
    logic                      quad_hit;
    logic                      issue_sum;
    raster_out_t               stamp_word;
    raster_out_t               sum_word;

    assign quad_ready = !out_req && !ack_wait && !sum_pend;
    assign quad_fire  = quad_valid && quad_ready;
    assign quad_hit   = quad_fire && (quad_mask != '0);
    assign issue_sum  = !out_req && !ack_wait && sum_pend;

    always_comb begin
        stamp_word             = '0;
        stamp_word.stamp.pos_x = POS_BITS'(quad_x >> QUAD_SHIFT);
        stamp_word.stamp.pos_y = POS_BITS'(quad_y >> QUAD_SHIFT);
        stamp_word.stamp.mask  = quad_mask;
        stamp_word.stamp.pid   = quad_pid;
    end

    always_comb begin
        sum_word               = '0;
        sum_word.summary.count = count;
        sum_word.summary.pid   = sum_pid;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_req  <= 1'b0;
            ack_wait <= 1'b0;
            sum_pend <= 1'b0;
            count    <= '0;
        end else begin
            if (quad_hit || issue_sum) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req <= 1'b0;
            end
            // Hold off until the receiver lets go of ack
            if (out_req && out_ack) begin
                ack_wait <= 1'b1;
            end else if (!out_ack) begin
                ack_wait <= 1'b0;
            end
            if (issue_sum) begin
                sum_pend <= 1'b0;
            end else if (quad_fire) begin
                sum_pend <= quad_last;
            end
            if (issue_sum) begin
                count <= '0;
            end else if (quad_hit) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (quad_fire) begin
            sum_pid <= quad_pid;
        end
        if (quad_hit) begin
            out_word       <= stamp_word;
            out_is_summary <= 1'b0;
        end else if (issue_sum) begin
            out_word       <= sum_word;
            out_is_summary <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        out_req |=> !out_req || ($stable(out_word) && $stable(out_is_summary)));

endmodule

// File: logic/raster_top.sv
////////////////////
// Raster top
// Decode, execute and result stages of the tile rasterizer
////////////////////
`timescale 1ns/1ps

module raster_top import raster_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_req,
    input  logic [DIM_BITS-1:0]         xloc,
    input  logic [DIM_BITS-1:0]         yloc,
    input  logic [PID_BITS-1:0]         pid,
    input  logic signed [COEF_BITS-1:0] a0,
    input  logic signed [COEF_BITS-1:0] b0,
    input  logic signed [COEF_BITS-1:0] c0,
    input  logic signed [COEF_BITS-1:0] a1,
    input  logic signed [COEF_BITS-1:0] b1,
    input  logic signed [COEF_BITS-1:0] c1,
    input  logic signed [COEF_BITS-1:0] a2,
    input  logic signed [COEF_BITS-1:0] b2,
    input  logic signed [COEF_BITS-1:0] c2,
    input  logic                        out_ack,
    output logic                        in_ack,
    output logic                        out_req,
    output logic                        out_is_summary,
    output raster_out_t                 out_word
);

    logic                        prim_valid;
    logic                        prim_take;
    logic signed [EDGE_BITS-1:0] e0;
    logic signed [EDGE_BITS-1:0] e1;
    logic signed [EDGE_BITS-1:0] e2;
    logic signed [COEF_BITS-1:0] ea0;
    logic signed [COEF_BITS-1:0] eb0;
    logic signed [COEF_BITS-1:0] ea1;
    logic signed [COEF_BITS-1:0] eb1;
    logic signed [COEF_BITS-1:0] ea2;
    logic signed [COEF_BITS-1:0] eb2;
    logic [DIM_BITS-1:0]         prim_x;
    logic [DIM_BITS-1:0]         prim_y;
    logic [PID_BITS-1:0]         prim_pid;

    logic                        quad_valid;
    logic                        quad_ready;
    logic [DIM_BITS-1:0]         quad_x;
    logic [DIM_BITS-1:0]         quad_y;
    logic [QUAD_MASK_BITS-1:0]   quad_mask;
    logic [PID_BITS-1:0]         quad_pid;
    logic                        quad_last;

    raster_decode raster_decode_inst (
        .clk        (clk),
        .reset      (reset),
        .in_req     (in_req),
        .xloc       (xloc),
        .yloc       (yloc),
        .pid        (pid),
        .a0         (a0),
        .b0         (b0),
        .c0         (c0),
        .a1         (a1),
        .b1         (b1),
        .c1         (c1),
        .a2         (a2),
        .b2         (b2),
        .c2         (c2),
        .prim_take  (prim_take),
        .in_ack     (in_ack),
        .prim_valid (prim_valid),
        .e0         (e0),
        .e1         (e1),
        .e2         (e2),
        .ea0        (ea0),
        .eb0        (eb0),
        .ea1        (ea1),
        .eb1        (eb1),
        .ea2        (ea2),
        .eb2        (eb2),
        .prim_x     (prim_x),
        .prim_y     (prim_y),
        .prim_pid   (prim_pid)
    );

    raster_execute raster_execute_inst (
        .clk        (clk),
        .reset      (reset),
        .prim_valid (prim_valid),
        .e0         (e0),
        .e1         (e1),
        .e2         (e2),
        .ea0        (ea0),
        .eb0        (eb0),
        .ea1        (ea1),
        .eb1        (eb1),
        .ea2        (ea2),
        .eb2        (eb2),
        .prim_x     (prim_x),
        .prim_y     (prim_y),
        .prim_pid   (prim_pid),
        .quad_ready (quad_ready),
        .prim_take  (prim_take),
        .quad_valid (quad_valid),
        .quad_x     (quad_x),
        .quad_y     (quad_y),
        .quad_mask  (quad_mask),
        .quad_pid   (quad_pid),
        .quad_last  (quad_last)
    );

    raster_result raster_result_inst (
        .clk            (clk),
        .reset          (reset),
        .quad_valid     (quad_valid),
        .quad_x         (quad_x),
        .quad_y         (quad_y),
        .quad_mask      (quad_mask),
        .quad_pid       (quad_pid),
        .quad_last      (quad_last),
        .out_ack        (out_ack),
        .quad_ready     (quad_ready),
        .out_req        (out_req),
        .out_is_summary (out_is_summary),
        .out_word       (out_word)
    );

endmodule

// File: tb/raster_tb.sv
////////////////////
// Rasterizer testbench
// Replays golden primitives through the DUT and checks every
// stamp and summary in order under random output back-pressure
////////////////////
`timescale 1ns/1ps

module raster_tb import raster_pkg::*; ();

    localparam string GOLDEN_FILE = "tb/raster_golden.txt";
    localparam int    WAIT_LIMIT  = 200;
    localparam int    MAX_PRIMS   = 32;
    localparam int    MAX_RECORDS = 128;
    localparam int    PRIM_COLS   = 12;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        in_req;
    logic [DIM_BITS-1:0]         xloc;
    logic [DIM_BITS-1:0]         yloc;
    logic [PID_BITS-1:0]         pid;
    logic signed [COEF_BITS-1:0] a0;
    logic signed [COEF_BITS-1:0] b0;
    logic signed [COEF_BITS-1:0] c0;
    logic signed [COEF_BITS-1:0] a1;
    logic signed [COEF_BITS-1:0] b1;
    logic signed [COEF_BITS-1:0] c1;
    logic signed [COEF_BITS-1:0] a2;
    logic signed [COEF_BITS-1:0] b2;
    logic signed [COEF_BITS-1:0] c2;
    logic                        out_ack;
    logic                        in_ack;
    logic                        out_req;
    logic                        out_is_summary;
    raster_out_t                 out_word;

    // Columns are pid, xloc, yloc, a0, b0, c0, a1, b1, c1, a2, b2, c2
    int          prim_tab [MAX_PRIMS][PRIM_COLS];
    raster_out_t exp_word [MAX_RECORDS];
    logic        exp_sum  [MAX_RECORDS];
    int          num_prims;
    int          num_exp;
    int          seed;

    always #4 clk = ~clk;

    raster_top raster_top_inst (
        .clk            (clk),
        .reset          (reset),
        .in_req         (in_req),
        .xloc           (xloc),
        .yloc           (yloc),
        .pid            (pid),
        .a0             (a0),
        .b0             (b0),
        .c0             (c0),
        .a1             (a1),
        .b1             (b1),
        .c1             (c1),
        .a2             (a2),
        .b2             (b2),
        .c2             (c2),
        .out_ack        (out_ack),
        .in_ack         (in_ack),
        .out_req        (out_req),
        .out_is_summary (out_is_summary),
        .out_word       (out_word)
    );

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string what, input int got, input int exp);
        $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        stop_run();
    endtask

    task automatic check_stamp(input raster_out_t got, input logic is_sum,
                               input raster_out_t exp);
        if (is_sum !== 1'b0) begin
            report_mismatch("record kind (1 = summary)", is_sum, 0);
        end
        if (got.stamp.pid !== exp.stamp.pid) begin
            report_mismatch("stamp pid", got.stamp.pid, exp.stamp.pid);
        end
        if (got.stamp.pos_x !== exp.stamp.pos_x) begin
            report_mismatch("stamp pos_x", got.stamp.pos_x, exp.stamp.pos_x);
        end
        if (got.stamp.pos_y !== exp.stamp.pos_y) begin
            report_mismatch("stamp pos_y", got.stamp.pos_y, exp.stamp.pos_y);
        end
        if (got.stamp.mask !== exp.stamp.mask) begin
            report_mismatch("stamp mask", got.stamp.mask, exp.stamp.mask);
        end
    endtask

    task automatic check_summary(input raster_out_t got, input logic is_sum,
                                 input raster_out_t exp);
        if (is_sum !== 1'b1) begin
            report_mismatch("record kind (1 = summary)", is_sum, 1);
        end
        if (got.summary.pid !== exp.summary.pid) begin
            report_mismatch("summary pid", got.summary.pid, exp.summary.pid);
        end
        if (got.summary.count !== exp.summary.count) begin
            report_mismatch("summary count", got.summary.count, exp.summary.count);
        end
        if (got.summary.pad !== exp.summary.pad) begin
            report_mismatch("summary padding", got.summary.pad, exp.summary.pad);
        end
    endtask

    task automatic read_golden();
        int          fd;
        int          c;
        int          code;
        int          k;
        int          f [PRIM_COLS];
        logic [7:0]  tag;
        raster_out_t w;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            report_error("cannot open the golden file tb/raster_golden.txt");
        end
        num_prims = 0;
        num_exp   = 0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            w = '0;
            if (tag == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (tag == "P") begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d",
                               f[0], f[1], f[2], f[3], f[4], f[5],
                               f[6], f[7], f[8], f[9], f[10], f[11]);
                if (code != PRIM_COLS) begin
                    report_error("a primitive line in the golden file is incomplete");
                end
                for (k = 0; k < PRIM_COLS; k++) begin
                    prim_tab[num_prims][k] = f[k];
                end
                num_prims++;
            end else if (tag == "S") begin
                code = $fscanf(fd, "%d %d %d %d", f[0], f[1], f[2], f[3]);
                if (code != 4) begin
                    report_error("a stamp line in the golden file is incomplete");
                end
                // Golden positions are pixels while the word carries quad units
                w.stamp.pos_x     = POS_BITS'(f[0] / QUAD_SIZE);
                w.stamp.pos_y     = POS_BITS'(f[1] / QUAD_SIZE);
                w.stamp.mask      = QUAD_MASK_BITS'(f[2]);
                w.stamp.pid       = PID_BITS'(f[3]);
                exp_word[num_exp] = w;
                exp_sum[num_exp]  = 1'b0;
                num_exp++;
            end else if (tag == "Q") begin
                code = $fscanf(fd, "%d %d", f[0], f[1]);
                if (code != 2) begin
                    report_error("a summary line in the golden file is incomplete");
                end
                w.summary.pid     = PID_BITS'(f[0]);
                w.summary.count   = STAMP_CNT_BITS'(f[1]);
                exp_word[num_exp] = w;
                exp_sum[num_exp]  = 1'b1;
                num_exp++;
            end else begin
                report_error("the golden file holds an unknown record type");
            end
        end
        $fclose(fd);
        if (num_prims == 0) begin
            report_error("the golden file holds no primitives");
        end
    endtask

    task automatic wait_in_ack(input logic level);
        int cycles;
        cycles = 0;
        while (in_ack !== level) begin
            if (cycles == WAIT_LIMIT) begin
                report_error($sformatf("timed out waiting for in_ack to become %0b", level));
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic wait_out_req(input logic level);
        int cycles;
        cycles = 0;
        while (out_req !== level) begin
            if (cycles == WAIT_LIMIT) begin
                report_error($sformatf("timed out waiting for out_req to become %0b", level));
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    // Four-phase input side with one primitive per request
    task automatic drive_prims();
        int i;
        for (i = 0; i < num_prims; i++) begin
            pid    = PID_BITS'(prim_tab[i][0]);
            xloc   = DIM_BITS'(prim_tab[i][1]);
            yloc   = DIM_BITS'(prim_tab[i][2]);
            a0     = COEF_BITS'(prim_tab[i][3]);
            b0     = COEF_BITS'(prim_tab[i][4]);
            c0     = COEF_BITS'(prim_tab[i][5]);
            a1     = COEF_BITS'(prim_tab[i][6]);
            b1     = COEF_BITS'(prim_tab[i][7]);
            c1     = COEF_BITS'(prim_tab[i][8]);
            a2     = COEF_BITS'(prim_tab[i][9]);
            b2     = COEF_BITS'(prim_tab[i][10]);
            c2     = COEF_BITS'(prim_tab[i][11]);
            in_req = 1'b1;
            wait_in_ack(1'b1);
            in_req = 1'b0;
            wait_in_ack(1'b0);
        end
    endtask

    // Output side acks 0 to 3 cycles after each request
    task automatic watch_outputs();
        int          i;
        int          delay;
        raster_out_t first_word;
        logic        first_kind;
        for (i = 0; i < num_exp; i++) begin
            wait_out_req(1'b1);
            first_word = out_word;
            first_kind = out_is_summary;
            if (exp_sum[i]) begin
                check_summary(out_word, out_is_summary, exp_word[i]);
            end else begin
                check_stamp(out_word, out_is_summary, exp_word[i]);
            end
            delay = {$random(seed)} % 4;
            repeat (delay) begin
                @(posedge clk);
                #1;
                if (out_req !== 1'b1) begin
                    report_error("out_req dropped before out_ack was raised");
                end
                if (out_word !== first_word || out_is_summary !== first_kind) begin
                    report_error("the output record changed while out_req was high");
                end
            end
            out_ack = 1'b1;
            wait_out_req(1'b0);
            out_ack = 1'b0;
        end
    endtask

    // Nothing may follow the last expected record
    task automatic check_quiet();
        repeat (20) begin
            @(posedge clk);
            #1;
            if (out_req !== 1'b0) begin
                report_error("the DUT sent a record after the last expected one");
            end
        end
    endtask

    initial begin
        reset   = 1'b1;
        in_req  = 1'b0;
        xloc    = '0;
        yloc    = '0;
        pid     = '0;
        a0      = '0;
        b0      = '0;
        c0      = '0;
        a1      = '0;
        b1      = '0;
        c1      = '0;
        a2      = '0;
        b2      = '0;
        c2      = '0;
        out_ack = 1'b0;
        seed    = 40820;
        read_golden();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            drive_prims();
            watch_outputs();
        join
        check_quiet();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: tb/raster_golden.txt
# P pid xloc yloc a0 b0 c0 a1 b1 c1 a2 b2 c2   (decimal, coefficients signed)
# S x y mask pid   (pixel position of the quad)   Q pid count
P 1 8 4 1 0 -7 0 1 -3 -1 -1 20
S 8 4 15 1
S 10 4 15 1
S 8 6 15 1
S 10 6 15 1
Q 1 4
P 2 0 0 -1 1 0 0 0 1 0 0 1
S 0 0 13 2
S 0 2 15 2
S 2 2 13 2
Q 2 3
P 3 16 16 0 0 -1 0 0 1 0 0 1
Q 3 0
P 4 20 8 1 2 -38 -2 1 36 0 -1 11
S 20 8 12 4
S 22 8 5 4
S 20 10 15 4
S 22 10 15 4
Q 4 4
P 5 0 32 1 1 -34 0 0 1 0 0 1
S 0 32 8 5
S 2 32 15 5
S 0 34 15 5
S 2 34 15 5
Q 5 4
P 6 40 40 1 -1 0 0 0 1 0 0 1
S 40 40 11 6
S 42 40 15 6
S 42 42 11 6
Q 6 3

// File: compile.f
logic/raster_pkg.sv
logic/raster_decode.sv
logic/raster_execute.sv
logic/raster_result.sv
logic/raster_top.sv
tb/raster_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the rasterizer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module raster_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vraster_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -Fqx '** PASS **' "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
